//--- Makefile
all: run

build:
	verilator --binary --timing --assert --top-module link_to_cache_tb -f vlog.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --top-module link_to_cache_tb -f vlog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- bench/link_cache_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link to cache port checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module link_cache_checker
  import link_cache_pkg::*;
#(
  parameter int num_tags_p = 8,
  parameter int tag_stride_p = 32
) (
  input logic           clk_i,
  input logic           reset_i,
  input logic           packet_yumi_i,
  input cache_pkt_s     cmd_i,
  input logic           cmd_v_i,
  input logic           cmd_ready_i,
  input logic           resp_v_i,
  input logic           resp_yumi_i,
  input return_packet_s return_packet_i,
  input logic           return_v_i,
  input logic           return_ready_i,
  input logic           wh_dest_i
);

  cache_pkt_s exp_cmd_q [$];
  logic exp_wh_q [$];
  return_packet_s exp_ret_q [$];
  int errors = 0;
  int cmd_count = 0;
  int ret_count = 0;
  int init_resp = 0;
  logic wh_pending = 1'b0;
  logic wh_exp;

  function void add_expected(input cache_pkt_s cmd, input logic wh,
                             input return_packet_s ret);
    exp_cmd_q.push_back(cmd);
    exp_wh_q.push_back(wh);
    exp_ret_q.push_back(ret);
  endfunction

  always @(negedge clk_i) begin
    cache_pkt_s exp_cmd;
    return_packet_s exp_ret;
    if (!reset_i) begin
      // direction register settles one edge after acceptance
      if (wh_pending) begin
        if (wh_dest_i !== wh_exp) begin
          errors++;
          $display("FAILED wh_dir %0d: expected %0b, actual %0b",
                   cmd_count - num_tags_p - 1, wh_exp, wh_dest_i);
        end
        wh_pending = 1'b0;
      end
      if (packet_yumi_i && init_resp < num_tags_p) begin
        errors++;
        $display("request consumed before tag init finished");
      end
      if (resp_v_i && resp_yumi_i && init_resp < num_tags_p)
        init_resp++;
      if (cmd_v_i && cmd_ready_i) begin
        if (cmd_count < num_tags_p) begin
          exp_cmd = {TAGST, cache_addr_width_gp'(cmd_count * tag_stride_p),
                     data_width_gp'(0), mask_width_gp'(0)};
          if (cmd_i !== exp_cmd) begin
            errors++;
            $display("FAILED tag_init %0d: expected %h, actual %h", cmd_count, exp_cmd, cmd_i);
          end
        end else if (exp_cmd_q.size() == 0) begin
          errors++;
          $display("cache command accepted with no request pending");
        end else begin
          exp_cmd = exp_cmd_q.pop_front();
          wh_exp = exp_wh_q.pop_front();
          wh_pending = 1'b1;
          if (cmd_i !== exp_cmd) begin
            errors++;
            $display("FAILED cmd %0d: expected %h, actual %h",
                     cmd_count - num_tags_p, exp_cmd, cmd_i);
          end
        end
        cmd_count++;
      end
      if (return_v_i && return_ready_i) begin
        if (exp_ret_q.size() == 0) begin
          errors++;
          $display("return packet sent with no response expected");
        end else begin
          exp_ret = exp_ret_q.pop_front();
          if (return_packet_i !== exp_ret) begin
            errors++;
            $display("FAILED return %0d: expected %h, actual %h",
                     ret_count, exp_ret, return_packet_i);
          end
        end
        ret_count++;
      end
    end
  end

endmodule

//--- bench/link_to_cache_golden.txt
// op addr payload reg_id x y | opcode cache_addr data mask | resp_data | type ret_reg | wh
// all hex, one request per line
2 0010 00000000 03 1 2  04 00040 00000000 3  11223344  1 03  0
2 0123 00000011 04 2 3  00 0048d 00000011 4  0000007f  1 04  0
2 0200 00000017 05 3 4  01 00803 00000017 5  000000ff  1 05  0
2 0004 0000000a 06 4 5  02 00012 0000000a 6  ffff8000  1 06  0
2 0008 0000002c 07 5 6  03 00020 0000002c 7  00001234  2 07  0
2 0100 00000040 08 6 7  04 00400 00000040 8  00000013  3 08  0
0 0020 1a2b3c4d 03 7 8  05 00080 1a2b3c4d 3  00000000  0 0b  0
0 0024 deadbeef 0f 8 9  05 00090 deadbeef f  00000000  0 00  0
0 0028 12345678 0e 9 a  05 000a0 12345678 e  00000000  0 18  0
1 0030 cafef00d 09 a b  05 000c0 cafef00d f  00000000  0 09  0
4 0040 00000001 0a b c  0c 00100 00000001 a  00000005  1 0a  0
5 0041 000000f0 0b c d  0d 00104 000000f0 b  0000000f  1 0b  0
6 0042 00000010 0c d e  0e 00108 00000010 c  00000020  1 0c  0
7 0043 fffffff0 0d e f  0f 0010c fffffff0 d  80000001  1 0d  0
8 0044 7fffffff 0e f 0  10 00110 7fffffff e  00000002  1 0e  0
9 0045 00000003 11 0 1  11 00114 00000003 1  00000004  1 11  0
a 0046 80000000 12 1 2  12 00118 80000000 2  7ffffffe  1 12  0
3 0050 00000000 00 2 3  09 00140 00000000 0  00000000  0 00  0
3 0051 00001500 01 3 4  0a 00144 00001500 1  00000000  0 15  0
3 0052 00000033 02 4 5  0b 00148 00000033 2  00000000  0 13  0
0 8004 00abc000 0f 5 6  06 00010 00abc000 f  00000000  0 00  0
2 8008 00000000 13 6 7  07 00020 00000000 3  00abc000  1 13  0
3 800c 00000000 00 7 8  08 00030 00000000 0  00000000  0 00  0
0 c000 00000001 0f 8 9  07 10000 00000001 f  00000000  0 00  1
1 c000 00000000 00 9 a  07 10000 00000000 f  00000000  0 00  0

//--- bench/link_to_cache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link to cache testbench
// golden requests, cache model, timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module link_to_cache_tb
  import link_cache_pkg::*;
();

  localparam int lines_lp = 25;
  localparam int words_lp = 14;
  localparam int num_tags_lp = 8;
  localparam int limit_lp = 40 * lines_lp + 100;

  logic clk;
  logic reset;
  link_packet_s packet;
  logic packet_v;
  logic packet_yumi;
  return_packet_s return_packet;
  logic return_v;
  logic return_ready;
  cache_pkt_s cache_pkt;
  logic cache_v;
  logic cache_ready;
  logic [data_width_gp-1:0] cache_data;
  logic cache_resp_v;
  logic cache_yumi;
  logic v_we;
  logic wh_dest;

  logic [31:0] gold [0:lines_lp*words_lp-1];
  logic [31:0] resp_q [$];
  logic [31:0] rnd = 32'h2faa_5f38;
  logic cmd_take;
  logic resp_take;
  logic rst_s;
  logic tl_v;
  logic tv_v;
  logic [data_width_gp-1:0] tl_data;
  logic [data_width_gp-1:0] tv_data;
  int taken;
  int cycles;

  link_to_cache #(
    .sets_p(4),
    .ways_p(2),
    .block_size_in_words_p(8)
  ) link_to_cache_inst (
    .clk_i(clk),
    .reset_i(reset),
    .packet_i(packet),
    .packet_v_i(packet_v),
    .packet_yumi_o(packet_yumi),
    .return_packet_o(return_packet),
    .return_v_o(return_v),
    .return_ready_i(return_ready),
    .cache_pkt_o(cache_pkt),
    .cache_v_o(cache_v),
    .cache_ready_i(cache_ready),
    .cache_data_i(cache_data),
    .cache_v_i(cache_resp_v),
    .cache_yumi_o(cache_yumi),
    .v_we_i(v_we),
    .wh_dest_east_not_west_o(wh_dest)
  );

  link_cache_checker #(
    .num_tags_p(num_tags_lp),
    .tag_stride_p(32)
  ) checker_inst (
    .clk_i(clk),
    .reset_i(reset),
    .packet_yumi_i(packet_yumi),
    .cmd_i(cache_pkt),
    .cmd_v_i(cache_v),
    .cmd_ready_i(cache_ready),
    .resp_v_i(cache_resp_v),
    .resp_yumi_i(cache_yumi),
    .return_packet_i(return_packet),
    .return_v_i(return_v),
    .return_ready_i(return_ready),
    .wh_dest_i(wh_dest)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // handshakes seen at the falling edge, acted on after the rising edge
  always @(negedge clk) begin
    cmd_take = cache_v && cache_ready;
    resp_take = cache_resp_v && cache_yumi;
    rst_s = reset;
  end

  // cache model: lookup and verify stages, up to two commands in flight
  always @(posedge clk) begin
    #2;
    if (rst_s) begin
      tl_v = 1'b0;
      tv_v = 1'b0;
      taken = 0;
    end else begin
      if (resp_take)
        tv_v = 1'b0;
      // v_we was high through the last cycle, so lookup moved to verify
      if (v_we) begin
        tv_v = 1'b1;
        tv_data = tl_data;
        tl_v = 1'b0;
      end
      if (cmd_take) begin
        tl_v = 1'b1;
        // tag stores answer with zero
        if (taken < num_tags_lp)
          tl_data = 32'h0;
        else
          tl_data = resp_q.pop_front();
        taken++;
      end
    end
    rnd = xorshift(rnd);
    v_we = tl_v && !tv_v;
    cache_ready = !rst_s && (!tl_v || v_we) && rnd[0];
    return_ready = rnd[2] | rnd[3];
    cache_resp_v = tv_v;
    cache_data = tv_data;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit_lp) begin
      $display("timeout after %0d cycles, %0d of %0d returns seen",
               cycles, checker_inst.ret_count, lines_lp);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    cycles = 0;
    taken = 0;
    tl_v = 1'b0;
    tv_v = 1'b0;
    tl_data = '0;
    tv_data = '0;
    rst_s = 1'b1;
    reset = 1'b1;
    packet = '0;
    packet_v = 1'b0;
    cache_ready = 1'b0;
    return_ready = 1'b0;
    cache_data = '0;
    cache_resp_v = 1'b0;
    v_we = 1'b0;
    $readmemh("bench/link_to_cache_golden.txt", gold);
    for (int i = 0; i < lines_lp; i++) begin
      int b;
      b = i * words_lp;
      checker_inst.add_expected(
        {cache_opcode_e'(gold[b+6][4:0]), gold[b+7][cache_addr_width_gp-1:0],
         gold[b+8], gold[b+9][mask_width_gp-1:0]},
        gold[b+13][0],
        {return_type_e'(gold[b+11][1:0]), gold[b+12][reg_id_width_gp-1:0],
         gold[b+5][y_cord_width_gp-1:0], gold[b+4][x_cord_width_gp-1:0], gold[b+10]});
      resp_q.push_back(gold[b+10]);
    end
    repeat (3) @(posedge clk);
    #2 reset = 1'b0;

    for (int i = 0; i < lines_lp; i++) begin
      int b;
      b = i * words_lp;
      @(posedge clk);
      #2;
      packet.op = net_op_e'(gold[b][3:0]);
      packet.addr = gold[b+1][link_addr_width_gp-1:0];
      packet.payload = gold[b+2];
      packet.reg_id = gold[b+3][reg_id_width_gp-1:0];
      packet.src_x_cord = gold[b+4][x_cord_width_gp-1:0];
      packet.src_y_cord = gold[b+5][y_cord_width_gp-1:0];
      packet_v = 1'b1;
      // held until the DUT consumes it
      do @(negedge clk); while (!packet_yumi);
    end
    @(posedge clk);
    #2 packet_v = 1'b0;

    while (checker_inst.ret_count < lines_lp)
      @(negedge clk);
    repeat (4) @(negedge clk);

    $display("commands %0d, returns %0d, errors %0d",
             checker_inst.cmd_count, checker_inst.ret_count, checker_inst.errors);
    if (checker_inst.errors == 0 && checker_inst.cmd_count == num_tags_lp + lines_lp
        && checker_inst.ret_count == lines_lp) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/link_cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link to cache shared types
// widths, opcodes and packet structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package link_cache_pkg;

  localparam int link_addr_width_gp = 16;
  localparam int data_width_gp = 32;
  localparam int mask_width_gp = data_width_gp / 8;
  // word address minus the space bit, plus byte offset
  localparam int cache_addr_width_gp = link_addr_width_gp - 1 + 2;
  localparam int x_cord_width_gp = 4;
  localparam int y_cord_width_gp = 4;
  localparam int reg_id_width_gp = 5;

  typedef enum logic [3:0] {
    e_remote_store   = 4'd0,
    e_remote_sw      = 4'd1,
    e_remote_load    = 4'd2,
    e_cache_op       = 4'd3,
    e_remote_amoswap = 4'd4,
    e_remote_amoor   = 4'd5,
    e_remote_amoadd  = 4'd6,
    e_remote_amomin  = 4'd7,
    e_remote_amomax  = 4'd8,
    e_remote_amominu = 4'd9,
    e_remote_amomaxu = 4'd10
  } net_op_e;

  // maintenance kind, carried in the reg id field
  typedef enum logic [1:0] {
    e_afl    = 2'd0,
    e_aflinv = 2'd1,
    e_ainv   = 2'd2
  } cache_op_e;

  typedef enum logic [4:0] {
    LB, LBU, LH, LHU, LW,
    SM,
    TAGST, TAGLA, TAGFL,
    AFL, AFLINV, AINV,
    AMOSWAP_W, AMOOR_W, AMOADD_W, AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W
  } cache_opcode_e;

  typedef enum logic [1:0] {
    e_return_credit   = 2'd0,
    e_return_int_wb   = 2'd1,
    e_return_float_wb = 2'd2,
    e_return_ifetch   = 2'd3
  } return_type_e;

  // lives in the low payload bits of a load
  typedef struct packed {
    logic       icache_fetch;
    logic       float_wb;
    logic       is_byte_op;
    logic       is_hex_op;
    logic       is_unsigned_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    net_op_e                      op;
    logic [link_addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0]      payload;
    logic [reg_id_width_gp-1:0]    reg_id;
    logic [x_cord_width_gp-1:0]    src_x_cord;
    logic [y_cord_width_gp-1:0]    src_y_cord;
  } link_packet_s;

  typedef struct packed {
    cache_opcode_e                  opcode;
    logic [cache_addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0]       data;
    logic [mask_width_gp-1:0]       mask;
  } cache_pkt_s;

  typedef struct packed {
    return_type_e               pkt_type;
    logic [reg_id_width_gp-1:0] reg_id;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [x_cord_width_gp-1:0] x_cord;
  } track_info_s;

  typedef struct packed {
    track_info_s              info;
    logic [data_width_gp-1:0] data;
  } return_packet_s;

endpackage

//--- hdl/link_to_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// network link to cache adapter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module link_to_cache
  import link_cache_pkg::*;
#(
  parameter int sets_p = 4,
  parameter int ways_p = 2,
  parameter int block_size_in_words_p = 8
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  // network side
  input  link_packet_s             packet_i,
  input  logic                     packet_v_i,
  output logic                     packet_yumi_o,
  output return_packet_s           return_packet_o,
  output logic                     return_v_o,
  input  logic                     return_ready_i,

  // cache side
  output cache_pkt_s               cache_pkt_o,
  output logic                     cache_v_o,
  input  logic                     cache_ready_i,
  input  logic [data_width_gp-1:0] cache_data_i,
  input  logic                     cache_v_i,
  output logic                     cache_yumi_o,
  input  logic                     v_we_i,

  output logic                     wh_dest_east_not_west_o
);

  cache_pkt_s clear_pkt;
  logic clear_v;
  logic init_done;
  cache_pkt_s xlat_pkt;
  track_info_s xlat_info;
  logic accept;

  // metadata for the lookup and verify stages
  track_info_s tl_info_r;
  track_info_s tv_info_r;

  tag_clear_seq #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_size_in_words_p(block_size_in_words_p)
  ) tag_clear_seq_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cache_ready_i(cache_ready_i),
    .cache_v_i(cache_v_i),
    .clear_pkt_o(clear_pkt),
    .clear_v_o(clear_v),
    .init_done_o(init_done)
  );

  req_translate req_translate_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .packet_i(packet_i),
    .accept_i(accept),
    .cache_pkt_o(xlat_pkt),
    .info_o(xlat_info),
    .wh_dest_east_not_west_o(wh_dest_east_not_west_o)
  );

  // clearer owns the cache port until init is done
  assign cache_pkt_o = init_done ? xlat_pkt : clear_pkt;
  assign cache_v_o = init_done ? packet_v_i : clear_v;
  assign accept = init_done && packet_v_i && cache_ready_i;
  assign packet_yumi_o = accept;

  // init responses are dropped straight away
  assign cache_yumi_o = init_done ? (cache_v_i && return_ready_i) : cache_v_i;
  assign return_v_o = init_done && cache_v_i;

  always_ff @(posedge clk_i) begin
    if (accept)
      tl_info_r <= xlat_info;
    if (v_we_i)
      tv_info_r <= tl_info_r;
  end

  assign return_packet_o.info = tv_info_r;
  assign return_packet_o.data = cache_data_i;

  // a stalled response must still be there next cycle, unchanged
  assert property (@(posedge clk_i) disable iff (reset_i)
    (return_v_o && !return_ready_i) |=> (cache_v_i && $stable(cache_data_i)))
    else $error("link to cache: stalled response dropped or changed");

endmodule

//--- hdl/req_translate.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request to cache command decode
// also holds the wormhole direction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module req_translate
  import link_cache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  link_packet_s packet_i,
  input  logic         accept_i,
  output cache_pkt_s   cache_pkt_o,
  output track_info_s  info_o,
  output logic         wh_dest_east_not_west_o
);

  load_info_s load_info;
  logic cfg_space;
  logic tag_space;
  logic [mask_width_gp-1:0] pkt_mask;
  logic [reg_id_width_gp-1:0] store_reg_id;
  logic wh_dir_r;

  assign load_info = load_info_s'(packet_i.payload[$bits(load_info_s)-1:0]);
  assign pkt_mask = packet_i.reg_id[mask_width_gp-1:0];
  assign cfg_space = (packet_i.addr[link_addr_width_gp-1-:2] == 2'b11);
  assign tag_space = packet_i.addr[link_addr_width_gp-1];

  // opcode by address space, then by operation
  always_comb begin
    cache_pkt_o.opcode = TAGLA;
    if (cfg_space) begin
      // config store rides through the cache as a no-op
      cache_pkt_o.opcode = TAGLA;
    end else if (tag_space) begin
      case (packet_i.op)
        e_remote_store, e_remote_sw: cache_pkt_o.opcode = TAGST;
        e_remote_load: cache_pkt_o.opcode = TAGLA;
        e_cache_op: cache_pkt_o.opcode = TAGFL;
        default: cache_pkt_o.opcode = TAGLA;
      endcase
    end else begin
      case (packet_i.op)
        e_remote_store, e_remote_sw: cache_pkt_o.opcode = SM;
        e_remote_amoswap: cache_pkt_o.opcode = AMOSWAP_W;
        e_remote_amoor: cache_pkt_o.opcode = AMOOR_W;
        e_remote_amoadd: cache_pkt_o.opcode = AMOADD_W;
        e_remote_amomin: cache_pkt_o.opcode = AMOMIN_W;
        e_remote_amomax: cache_pkt_o.opcode = AMOMAX_W;
        e_remote_amominu: cache_pkt_o.opcode = AMOMINU_W;
        e_remote_amomaxu: cache_pkt_o.opcode = AMOMAXU_W;
        e_cache_op: begin
          case (cache_op_e'(packet_i.reg_id[1:0]))
            e_aflinv: cache_pkt_o.opcode = AFLINV;
            e_ainv: cache_pkt_o.opcode = AINV;
            default: cache_pkt_o.opcode = AFL;
          endcase
        end
        e_remote_load: begin
          if (load_info.is_byte_op)
            cache_pkt_o.opcode = load_info.is_unsigned_op ? LBU : LB;
          else if (load_info.is_hex_op)
            cache_pkt_o.opcode = load_info.is_unsigned_op ? LHU : LH;
          else
            cache_pkt_o.opcode = LW;
        end
        default: cache_pkt_o.opcode = AFL;
      endcase
    end
  end

  assign cache_pkt_o.data = packet_i.payload;
  assign cache_pkt_o.mask = (packet_i.op == e_remote_sw) ? '1 : pkt_mask;
  assign cache_pkt_o.addr = {
    packet_i.addr[link_addr_width_gp-2:0],
    (packet_i.op == e_remote_load) ? load_info.part_sel : 2'b00
  };

  // lowest byte with a clear mask bit holds the reg id
  always_comb begin
    store_reg_id = '0;
    for (int i = mask_width_gp - 1; i >= 0; i--) begin
      if (!pkt_mask[i])
        store_reg_id = packet_i.payload[8*i+:reg_id_width_gp];
    end
  end

  always_comb begin
    case (packet_i.op)
      e_remote_store, e_remote_sw, e_cache_op: info_o.pkt_type = e_return_credit;
      e_remote_load: begin
        if (load_info.icache_fetch)
          info_o.pkt_type = e_return_ifetch;
        else if (load_info.float_wb)
          info_o.pkt_type = e_return_float_wb;
        else
          info_o.pkt_type = e_return_int_wb;
      end
      default: info_o.pkt_type = e_return_int_wb;
    endcase
  end

  assign info_o.reg_id = (packet_i.op == e_remote_store || packet_i.op == e_cache_op)
    ? store_reg_id
    : packet_i.reg_id;
  assign info_o.y_cord = packet_i.src_y_cord;
  assign info_o.x_cord = packet_i.src_x_cord;

  always_ff @(posedge clk_i) begin
    if (reset_i)
      wh_dir_r <= 1'b0;
    else if (accept_i && cfg_space)
      wh_dir_r <= packet_i.payload[0];
  end

  assign wh_dest_east_not_west_o = wh_dir_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
    (accept_i && cfg_space) |-> (packet_i.op inside {e_remote_store, e_remote_sw}))
    else $error("req translate: non-store to config space");

  assert property (@(posedge clk_i) disable iff (reset_i)
    accept_i |-> (packet_i.op <= e_remote_amomaxu))
    else $error("req translate: undefined op %0d", packet_i.op);

endmodule

//--- hdl/tag_clear_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag clear sequencer
// zeroes every tag after reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tag_clear_seq
  import link_cache_pkg::*;
#(
  parameter int sets_p = 4,
  parameter int ways_p = 2,
  parameter int block_size_in_words_p = 8
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cache_ready_i,
  input  logic       cache_v_i,
  output cache_pkt_s clear_pkt_o,
  output logic       clear_v_o,
  output logic       init_done_o
);

  localparam int total_lp = sets_p * ways_p;
  localparam int count_width_lp = $clog2(total_lp + 1);
  localparam int block_offset_lp = $clog2(block_size_in_words_p) + $clog2(mask_width_gp);

  typedef enum logic [1:0] {e_reset, e_clear_tag, e_done} state_e;

  state_e state_r, state_n;
  logic [count_width_lp-1:0] sent_r, sent_n;
  logic [count_width_lp-1:0] recv_r, recv_n;

  assign clear_v_o = (state_r == e_clear_tag) && (sent_r != count_width_lp'(total_lp));
  assign init_done_o = (state_r == e_done);

  // set and way index sits above the block offset
  assign clear_pkt_o.opcode = TAGST;
  assign clear_pkt_o.addr = cache_addr_width_gp'(sent_r) << block_offset_lp;
  assign clear_pkt_o.data = '0;
  assign clear_pkt_o.mask = '0;

  always_comb begin
    sent_n = sent_r + count_width_lp'(clear_v_o && cache_ready_i);
    recv_n = recv_r + count_width_lp'((state_r == e_clear_tag) && cache_v_i);
    state_n = state_r;
    case (state_r)
      e_reset: state_n = e_clear_tag;
      e_clear_tag: begin
        // done once all stores are out and answered
        if (sent_n == count_width_lp'(total_lp) && recv_n == count_width_lp'(total_lp))
          state_n = e_done;
      end
      default: state_n = e_done;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      sent_r <= '0;
      recv_r <= '0;
    end else begin
      state_r <= state_n;
      sent_r <= sent_n;
      recv_r <= recv_n;
    end
  end

  // a response never shows up without an outstanding store
  assert property (@(posedge clk_i) disable iff (reset_i) recv_r <= sent_r)
    else $error("tag clear: more responses than commands");

endmodule

//--- vlog.f
hdl/link_cache_pkg.sv
hdl/tag_clear_seq.sv
hdl/req_translate.sv
hdl/link_to_cache.sv
bench/link_cache_checker.sv
bench/link_to_cache_tb.sv
